// File: flist.f
+incdir+hw
hw/soc_pkg.sv
hw/wb_master_bridge.sv
hw/wb_intercon.sv
hw/wb_data_mem.sv
hw/wb_gpio.sv
hw/soc_top.sv
tb/soc_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run soc_tb, check sim.log for the pass message"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module soc_tb \
		-f flist.f --Mdir obj_dir -o soc_tb_sim
	./obj_dir/soc_tb_sim | tee sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb/soc_tb.sv
`include "soc_consts.svh"

module soc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import soc_pkg::*;

    localparam int DEPTH = `SOC_DMEM_DEPTH;
    localparam int IW    = $clog2(DEPTH);
    // accesses per test: 160 + 32 + 68 + 12 + 11
    localparam int N_ACCESS    = 283;
    localparam int CYCLE_LIMIT = 8 * N_ACCESS + 100;

    logic      clk;
    logic      reset_i;
    proc_req_t proc_req_i;
    word_t     proc_rdata_o;
    logic      proc_stall_o;
    logic      proc_err_o;
    word_t     gpio_in_i;
    word_t     gpio_out_o;
    word_t     gpio_oe_o;

    // model state, owned by the driver
    word_t       model_mem [DEPTH];
    word_t       model_out;
    word_t       model_oe;
    word_t       model_in;
    word_t       exp_rdata;
    logic        exp_load;
    logic        exp_err;
    logic [15:0] lfsr_q;
    // issued and completed accesses
    int          req_count;
    int          done_count;
    // checker bookkeeping, owned by the monitor
    int          checks;
    int          errors;
    int          stall_cnt;
    int          stall_bad;
    logic        reset_checked;
    int          chk0;
    int          err0;
    int          cycle_cnt;

    soc_top u_dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .proc_req_i   (proc_req_i),
        .proc_rdata_o (proc_rdata_o),
        .proc_stall_o (proc_stall_o),
        .proc_err_o   (proc_err_o),
        .gpio_in_i    (gpio_in_i),
        .gpio_out_o   (gpio_out_o),
        .gpio_oe_o    (gpio_oe_o)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ========================================================================
    // random source and reference model
    // ========================================================================

    // fibonacci lfsr, x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_step(logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // one lfsr step per bit taken
    function automatic word_t draw(int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // expected load value: pick the lane(s), then extend
    function automatic word_t load_ref(word_t w, mem_op_t op, addr_t a);
        logic [7:0]  b;
        logic [15:0] h;
        case (a[1:0])
            2'd0:    b = w[7:0];
            2'd1:    b = w[15:8];
            2'd2:    b = w[23:16];
            default: b = w[31:24];
        endcase
        // bit 0 ignored for halfwords
        h = a[1] ? w[31:16] : w[15:0];
        case (op)
            OP_LB:   return {{24{b[7]}}, b};
            OP_LBU:  return {24'h0, b};
            OP_LH:   return {{16{h[15]}}, h};
            OP_LHU:  return {16'h0, h};
            default: return w;
        endcase
    endfunction

    // word after a store, only the addressed bytes change
    function automatic word_t store_merge(word_t old, word_t wd, mem_op_t op, addr_t a);
        word_t r;
        r = old;
        case (op)
            OP_LB, OP_LBU:
            begin
                case (a[1:0])
                    2'd0:    r[7:0]   = wd[7:0];
                    2'd1:    r[15:8]  = wd[7:0];
                    2'd2:    r[23:16] = wd[7:0];
                    default: r[31:24] = wd[7:0];
                endcase
            end
            OP_LH, OP_LHU:
            begin
                if (a[1])
                begin
                    r[31:16] = wd[15:0];
                end
                else
                begin
                    r[15:0] = wd[15:0];
                end
            end
            default: r = wd;
        endcase
        return r;
    endfunction

    // region 0 address, random upper bits exercise the index wrap
    function automatic addr_t mem_addr(int idx, logic [1:0] ofs);
        addr_t a;
        a = draw(28);
        a[31:28]  = `SOC_REGION_DMEM;
        a[IW+1:2] = idx[IW-1:0];
        a[1:0]    = ofs;
        return a;
    endfunction

    function automatic addr_t gpio_addr(logic [7:0] ofs);
        return {`SOC_REGION_GPIO, 20'h0, ofs};
    endfunction

    // ========================================================================
    // checker process
    // ========================================================================

    task automatic check(input string what, input word_t got, input word_t exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    always @(negedge clk)
    begin
        // first cycle out of reset
        if (!reset_i && !reset_checked)
        begin
            check("stall after reset", 32'(proc_stall_o), 32'd0);
            check("err after reset", 32'(proc_err_o), 32'd0);
            check("gpio_out after reset", gpio_out_o, 32'd0);
            check("gpio_oe after reset", gpio_oe_o, 32'd0);
            reset_checked = 1'b1;
        end
        if (req_count != done_count)
        begin
            if (proc_stall_o)
            begin
                stall_cnt++;
            end
            else
            begin
                // completion cycle
                if (stall_cnt != 3)
                begin
                    stall_bad++;
                end
                check("stall cycles", 32'(stall_cnt), 32'd3);
                check("proc_err_o", 32'(proc_err_o), 32'(exp_err));
                if (exp_load)
                begin
                    check("load data", proc_rdata_o, exp_rdata);
                end
                check("gpio_out_o", gpio_out_o, model_out);
                check("gpio_oe_o", gpio_oe_o, model_oe);
                stall_cnt  = 0;
                done_count = done_count + 1;
            end
        end
    end

    always @(posedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failures found");
            $finish;
        end
    end

    // ========================================================================
    // driver
    // ========================================================================

    // update the model, then hold the request until the checker sees completion
    task automatic do_access(input addr_t a, input word_t wd, input logic wr, input mem_op_t op);
        word_t         cur;
        logic          bad;
        logic [IW-1:0] idx;
        logic [7:0]    ofs;
        idx = a[IW+1:2];
        ofs = {a[7:2], 2'b00};
        bad = 1'b0;
        cur = '0;
        case (a[31:28])
            `SOC_REGION_DMEM:
            begin
                cur = model_mem[idx];
                if (wr)
                begin
                    model_mem[idx] = store_merge(cur, wd, op, a);
                end
            end
            `SOC_REGION_GPIO:
            begin
                if (ofs == `SOC_GPIO_OUT_OFS)
                begin
                    cur = model_out;
                    if (wr)
                    begin
                        model_out = store_merge(cur, wd, op, a);
                    end
                end
                else if (ofs == `SOC_GPIO_OE_OFS)
                begin
                    cur = model_oe;
                    if (wr)
                    begin
                        model_oe = store_merge(cur, wd, op, a);
                    end
                end
                else if (ofs == `SOC_GPIO_IN_OFS)
                begin
                    cur = model_in;
                end
            end
            default: bad = 1'b1;
        endcase
        exp_rdata = load_ref(cur, op, a);
        exp_load  = ~wr & ~bad;
        exp_err   = bad;

        @(posedge clk);
        #1;
        proc_req_i.addr  = a;
        proc_req_i.wdata = wd;
        proc_req_i.op    = op;
        proc_req_i.read  = ~wr;
        proc_req_i.write = wr;
        req_count = req_count + 1;
        while (done_count != req_count)
        begin
            @(posedge clk);
        end
        #1;
        proc_req_i.read  = 1'b0;
        proc_req_i.write = 1'b0;
    endtask

    task automatic store(input addr_t a, input word_t wd, input mem_op_t op);
        do_access(a, wd, 1'b1, op);
    endtask

    task automatic load(input addr_t a, input mem_op_t op);
        do_access(a, '0, 1'b0, op);
    endtask

    task automatic begin_test();
        chk0 = checks;
        err0 = errors;
    endtask

    task automatic end_test(input string name);
        $display("test %-22s %0d checks, %0d errors", name, checks - chk0, errors - err0);
    endtask

    initial
    begin
        int    idx;
        addr_t a;

        reset_i    = 1'b1;
        proc_req_i = '0;
        gpio_in_i  = '0;
        lfsr_q     = 16'd59;
        model_out  = '0;
        model_oe   = '0;
        model_in   = '0;
        exp_rdata  = '0;
        exp_load   = 1'b0;
        exp_err    = 1'b0;
        req_count  = 0;
        done_count = 0;
        checks     = 0;
        errors     = 0;
        stall_cnt  = 0;
        stall_bad  = 0;
        cycle_cnt  = 0;
        reset_checked = 1'b0;

        begin_test();
        repeat (5) @(posedge clk);
        #1;
        reset_i = 1'b0;
        repeat (2) @(posedge clk);
        end_test("reset state");

        // fill every word, then read back at random
        begin_test();
        for (int i = 0; i < DEPTH; i++)
        begin
            store(mem_addr(i, 2'(draw(2))), draw(32), OP_LW);
        end
        for (int i = 0; i < 32; i++)
        begin
            load(mem_addr(int'(draw(IW)), 2'(draw(2))), OP_LW);
        end
        end_test("word store/load");

        // sub-word stores at each lane, checked by word loads
        begin_test();
        for (int rep = 0; rep < 2; rep++)
        begin
            for (int o = 0; o < 4; o++)
            begin
                idx = int'(draw(IW));
                store(mem_addr(idx, o[1:0]), draw(32), OP_LB);
                load(mem_addr(idx, 2'b00), OP_LW);
                idx = int'(draw(IW));
                store(mem_addr(idx, o[1:0]), draw(32), OP_LH);
                load(mem_addr(idx, 2'b00), OP_LW);
            end
        end
        end_test("byte/half store");

        // load extension at every offset
        begin_test();
        for (int w = 0; w < 4; w++)
        begin
            idx = int'(draw(IW));
            store(mem_addr(idx, 2'b00), draw(32), OP_LW);
            for (int o = 0; o < 4; o++)
            begin
                load(mem_addr(idx, o[1:0]), OP_LB);
                load(mem_addr(idx, o[1:0]), OP_LBU);
                load(mem_addr(idx, o[1:0]), OP_LH);
                load(mem_addr(idx, o[1:0]), OP_LHU);
            end
        end
        end_test("load extension");

        begin_test();
        store(gpio_addr(`SOC_GPIO_OUT_OFS), draw(32), OP_LW);
        load(gpio_addr(`SOC_GPIO_OUT_OFS), OP_LW);
        store(gpio_addr(`SOC_GPIO_OE_OFS), draw(32), OP_LW);
        load(gpio_addr(`SOC_GPIO_OE_OFS), OP_LW);
        store(gpio_addr(`SOC_GPIO_OUT_OFS) + 32'd2, draw(32), OP_LB);
        store(gpio_addr(`SOC_GPIO_OE_OFS) + 32'd2, draw(32), OP_LH);
        load(gpio_addr(`SOC_GPIO_OUT_OFS), OP_LW);
        load(gpio_addr(`SOC_GPIO_OE_OFS), OP_LW);
        // new pin pattern, then past the synchronizer
        @(posedge clk);
        #1;
        gpio_in_i = draw(32);
        model_in  = gpio_in_i;
        repeat (2) @(posedge clk);
        load(gpio_addr(`SOC_GPIO_IN_OFS), OP_LW);
        store(gpio_addr(`SOC_GPIO_IN_OFS), draw(32), OP_LW);
        load(gpio_addr(`SOC_GPIO_IN_OFS), OP_LW);
        // unused offset reads zero
        load(gpio_addr(8'h0C), OP_LW);
        end_test("gpio registers");

        // regions 1, 5, 9 and D are unmapped
        begin_test();
        idx = int'(draw(IW));
        for (int k = 0; k < 4; k++)
        begin
            a = mem_addr(idx, 2'b00);
            a[31:28] = 4'(4 * k + 1);
            store(a, draw(32), OP_LW);
            load(a, OP_LW);
        end
        load(mem_addr(idx, 2'b00), OP_LW);
        load(gpio_addr(`SOC_GPIO_OUT_OFS), OP_LW);
        load(gpio_addr(`SOC_GPIO_OE_OFS), OP_LW);
        end_test("unmapped error");

        $display("test %-22s %0d accesses, %0d errors", "stall timing", done_count, stall_bad);
        $display("summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: hw/soc_top.sv
`include "soc_consts.svh"

module soc_top (
    input  logic               clk,
    input  logic               reset_i,
    input  soc_pkg::proc_req_t proc_req_i,
    output soc_pkg::word_t     proc_rdata_o,
    output logic               proc_stall_o,
    output logic               proc_err_o,
    input  soc_pkg::word_t     gpio_in_i,
    output soc_pkg::word_t     gpio_out_o,
    output soc_pkg::word_t     gpio_oe_o
);
    import soc_pkg::*;

    // master side of the interconnect
    wb_m2s_t bus_m2s;
    wb_s2m_t bus_s2m;
    // slave sides
    wb_m2s_t dmem_m2s;
    wb_s2m_t dmem_s2m;
    wb_m2s_t gpio_m2s;
    wb_s2m_t gpio_s2m;

    // ========================================================================
    // wishbone master
    // ========================================================================

    wb_master_bridge u_bridge (
        .clk          (clk),
        .reset_i      (reset_i),
        .proc_req_i   (proc_req_i),
        .proc_rdata_o (proc_rdata_o),
        .proc_stall_o (proc_stall_o),
        .proc_err_o   (proc_err_o),
        .wb_m_o       (bus_m2s),
        .wb_s_i       (bus_s2m)
    );

    wb_intercon u_intercon (
        .clk      (clk),
        .reset_i  (reset_i),
        .wb_m_i   (bus_m2s),
        .wb_s_o   (bus_s2m),
        .dmem_m_o (dmem_m2s),
        .gpio_m_o (gpio_m2s),
        .dmem_s_i (dmem_s2m),
        .gpio_s_i (gpio_s2m)
    );

    // ========================================================================
    // slaves
    // ========================================================================

    wb_data_mem #(
        .DEPTH (`SOC_DMEM_DEPTH)
    ) u_dmem (
        .clk     (clk),
        .reset_i (reset_i),
        .wb_i    (dmem_m2s),
        .wb_o    (dmem_s2m)
    );

    // pad buffers sit outside, only the vectors leave the top
    wb_gpio u_gpio (
        .clk        (clk),
        .reset_i    (reset_i),
        .wb_i       (gpio_m2s),
        .wb_o       (gpio_s2m),
        .gpio_in_i  (gpio_in_i),
        .gpio_out_o (gpio_out_o),
        .gpio_oe_o  (gpio_oe_o)
    );

endmodule

// File: hw/wb_gpio.sv
`include "soc_consts.svh"

module wb_gpio (
    input  logic             clk,
    input  logic             reset_i,
    input  soc_pkg::wb_m2s_t wb_i,
    output soc_pkg::wb_s2m_t wb_o,
    input  soc_pkg::word_t   gpio_in_i,
    output soc_pkg::word_t   gpio_out_o,
    output soc_pkg::word_t   gpio_oe_o
);
    import soc_pkg::*;

    word_t      out_q;
    word_t      oe_q;
    word_t      in_meta_q;
    word_t      in_sync_q;
    word_t      rdata_q;
    logic       ack_q;
    logic       access;
    logic [7:0] reg_ofs;

    assign reg_ofs = wb_i.adr[7:0];
    assign access  = wb_i.cyc & wb_i.stb & ~ack_q;

    // two-flop synchronizer on the pins
    always_ff @(posedge clk)
    begin
        in_meta_q <= gpio_in_i;
        in_sync_q <= in_meta_q;
    end

    // ========================================================================
    // output and enable registers
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            out_q <= '0;
            oe_q  <= '0;
        end
        else if (access && wb_i.we)
        begin
            for (int i = 0; i < 4; i++)
            begin
                if (wb_i.sel[i] && (reg_ofs == `SOC_GPIO_OUT_OFS))
                begin
                    out_q[8*i +: 8] <= wb_i.dat[8*i +: 8];
                end
                if (wb_i.sel[i] && (reg_ofs == `SOC_GPIO_OE_OFS))
                begin
                    oe_q[8*i +: 8] <= wb_i.dat[8*i +: 8];
                end
            end
        end
    end

    // read mux, registered with the ack
    always_ff @(posedge clk)
    begin
        if (access)
        begin
            case (reg_ofs)
                `SOC_GPIO_OUT_OFS: rdata_q <= out_q;
                `SOC_GPIO_OE_OFS:  rdata_q <= oe_q;
                `SOC_GPIO_IN_OFS:  rdata_q <= in_sync_q;
                default:           rdata_q <= '0;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= access;
        end
    end

    always_comb
    begin
        wb_o.dat = rdata_q;
        wb_o.ack = ack_q;
        wb_o.err = 1'b0;
    end

    assign gpio_out_o = out_q;
    assign gpio_oe_o  = oe_q;

endmodule

// File: hw/wb_data_mem.sv
`include "soc_consts.svh"

module wb_data_mem #(
    parameter int DEPTH = `SOC_DMEM_DEPTH
) (
    input  logic             clk,
    input  logic             reset_i,
    input  soc_pkg::wb_m2s_t wb_i,
    output soc_pkg::wb_s2m_t wb_o
);
    import soc_pkg::*;

    localparam int IW = $clog2(DEPTH);

    word_t         mem [DEPTH];
    word_t         rdata_q;
    logic          ack_q;
    logic [IW-1:0] idx;
    logic          access;

    // word index, wraps at the depth
    assign idx    = wb_i.adr[IW+1:2];
    // one access per strobe, none while ack is out
    assign access = wb_i.cyc & wb_i.stb & ~ack_q;

    always_ff @(posedge clk)
    begin
        if (access)
        begin
            if (wb_i.we)
            begin
                // selected bytes only
                for (int i = 0; i < 4; i++)
                begin
                    if (wb_i.sel[i])
                    begin
                        mem[idx][8*i +: 8] <= wb_i.dat[8*i +: 8];
                    end
                end
            end
            rdata_q <= mem[idx];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            ack_q <= 1'b0;
        end
        else
        begin
            ack_q <= access;
        end
    end

    always_comb
    begin
        wb_o.dat = rdata_q;
        wb_o.ack = ack_q;
        wb_o.err = 1'b0;
    end

endmodule

// File: hw/wb_intercon.sv
`include "soc_consts.svh"

module wb_intercon (
    input  logic             clk,
    input  logic             reset_i,
    input  soc_pkg::wb_m2s_t wb_m_i,
    output soc_pkg::wb_s2m_t wb_s_o,
    output soc_pkg::wb_m2s_t dmem_m_o,
    output soc_pkg::wb_m2s_t gpio_m_o,
    input  soc_pkg::wb_s2m_t dmem_s_i,
    input  soc_pkg::wb_s2m_t gpio_s_i
);

    logic [3:0] region;
    logic       hit_dmem;
    logic       hit_gpio;
    logic       err_q;

    // region code in the top nibble
    assign region   = wb_m_i.adr[31:28];
    assign hit_dmem = (region == `SOC_REGION_DMEM);
    assign hit_gpio = (region == `SOC_REGION_GPIO);

    // fan out, only the hit slave sees cyc and stb
    always_comb
    begin
        dmem_m_o     = wb_m_i;
        dmem_m_o.cyc = wb_m_i.cyc & hit_dmem;
        dmem_m_o.stb = wb_m_i.stb & hit_dmem;
        gpio_m_o     = wb_m_i;
        gpio_m_o.cyc = wb_m_i.cyc & hit_gpio;
        gpio_m_o.stb = wb_m_i.stb & hit_gpio;
    end

    // unmapped access answered here, one cycle after the strobe
    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            err_q <= 1'b0;
        end
        else
        begin
            err_q <= wb_m_i.cyc & wb_m_i.stb & ~hit_dmem & ~hit_gpio & ~err_q;
        end
    end

    // reply mux
    always_comb
    begin
        if (hit_dmem)
        begin
            wb_s_o = dmem_s_i;
        end
        else if (hit_gpio)
        begin
            wb_s_o = gpio_s_i;
        end
        else
        begin
            wb_s_o.dat = '0;
            wb_s_o.ack = 1'b0;
            wb_s_o.err = err_q;
        end
    end

endmodule

// File: hw/wb_master_bridge.sv
module wb_master_bridge (
    input  logic               clk,
    input  logic               reset_i,
    input  soc_pkg::proc_req_t proc_req_i,
    output soc_pkg::word_t     proc_rdata_o,
    output logic               proc_stall_o,
    output logic               proc_err_o,
    output soc_pkg::wb_m2s_t   wb_m_o,
    input  soc_pkg::wb_s2m_t   wb_s_i
);
    import soc_pkg::*;

    bridge_state_t state_q;
    wb_m2s_t       wb_q;
    word_t         rdata_q;
    logic          err_q;
    logic          req_valid;
    logic          bus_done;
    logic [1:0]    lane_ofs;
    sel_t          store_sel;
    word_t         store_dat;

    // shift the addressed lanes down and extend to 32 bits
    function automatic word_t load_extend(word_t raw, mem_op_t op, logic [1:0] ofs);
        word_t shifted;
        shifted = raw >> {ofs, 3'b000};
        case (op)
            OP_LB:   load_extend = {{24{shifted[7]}}, shifted[7:0]};
            OP_LH:   load_extend = {{16{shifted[15]}}, shifted[15:0]};
            OP_LBU:  load_extend = {24'h0, shifted[7:0]};
            OP_LHU:  load_extend = {16'h0, shifted[15:0]};
            default: load_extend = raw;
        endcase
    endfunction

    assign req_valid = proc_req_i.read | proc_req_i.write;

    // ========================================================================
    // lane steering
    // ========================================================================

    always_comb
    begin
        case (proc_req_i.op)
            OP_LB, OP_LBU:
            begin
                lane_ofs  = proc_req_i.addr[1:0];
                store_sel = 4'b0001 << lane_ofs;
                store_dat = {4{proc_req_i.wdata[7:0]}};
            end
            OP_LH, OP_LHU:
            begin
                // halfword ignores bit 0
                lane_ofs  = {proc_req_i.addr[1], 1'b0};
                store_sel = 4'b0011 << lane_ofs;
                store_dat = {2{proc_req_i.wdata[15:0]}};
            end
            default:
            begin
                // word and unknown sizes use all lanes
                lane_ofs  = 2'b00;
                store_sel = 4'b1111;
                store_dat = proc_req_i.wdata;
            end
        endcase
    end

    // ========================================================================
    // bus fsm
    // ========================================================================

    assign bus_done = wb_q.cyc & (wb_s_i.ack | wb_s_i.err);

    always_ff @(posedge clk)
    begin
        // address and data captured while idle
        if (state_q == ST_IDLE)
        begin
            wb_q.adr <= {proc_req_i.addr[31:2], 2'b00};
            wb_q.dat <= store_dat;
            wb_q.sel <= store_sel;
        end
        // load result taken with the reply
        if ((state_q == ST_BUS) && bus_done)
        begin
            rdata_q <= load_extend(wb_s_i.dat, proc_req_i.op, lane_ofs);
        end

        if (reset_i)
        begin
            state_q  <= ST_IDLE;
            wb_q.cyc <= 1'b0;
            wb_q.stb <= 1'b0;
            wb_q.we  <= 1'b0;
            err_q    <= 1'b0;
        end
        else
        begin
            case (state_q)
                ST_IDLE:
                begin
                    err_q <= 1'b0;
                    if (req_valid)
                    begin
                        wb_q.cyc <= 1'b1;
                        wb_q.stb <= 1'b1;
                        wb_q.we  <= proc_req_i.write;
                        state_q  <= ST_BUS;
                    end
                end
                ST_BUS:
                begin
                    // hold the cycle until ack or err
                    if (bus_done)
                    begin
                        wb_q.cyc <= 1'b0;
                        wb_q.stb <= 1'b0;
                        wb_q.we  <= 1'b0;
                        err_q    <= wb_s_i.err;
                        state_q  <= ST_DONE;
                    end
                end
                default:
                begin
                    // completion cycle, err pulse ends here
                    err_q   <= 1'b0;
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // stall from the request cycle through the bus cycle
    assign proc_stall_o = (state_q == ST_BUS) || ((state_q == ST_IDLE) && req_valid);
    assign proc_rdata_o = rdata_q;
    assign proc_err_o   = err_q;
    assign wb_m_o       = wb_q;

endmodule

// File: hw/soc_pkg.sv
package soc_pkg;

    // plain data and address widths
    typedef logic [31:0] word_t;
    typedef logic [31:0] addr_t;
    // one select bit per byte lane
    typedef logic [3:0]  sel_t;

    // load/store size, same codes as funct3
    typedef enum logic [2:0] {
        OP_LB  = 3'b000,
        OP_LH  = 3'b001,
        OP_LW  = 3'b010,
        OP_LBU = 3'b100,
        OP_LHU = 3'b101
    } mem_op_t;

    // processor load/store port, held until stall drops
    typedef struct packed {
        addr_t   addr;
        word_t   wdata;
        logic    read;
        logic    write;
        mem_op_t op;
    } proc_req_t;

    // wishbone master to slave
    typedef struct packed {
        addr_t adr;
        word_t dat;
        sel_t  sel;
        logic  we;
        logic  cyc;
        logic  stb;
    } wb_m2s_t;

    // wishbone slave to master
    typedef struct packed {
        word_t dat;
        logic  ack;
        logic  err;
    } wb_s2m_t;

    // bridge fsm
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_DONE
    } bridge_state_t;

endpackage

// File: hw/soc_consts.svh
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// ==========================================================================
// address map and memory sizing
// ==========================================================================

// data memory depth in 32-bit words
`define SOC_DMEM_DEPTH 128

// region codes live in address bits 31 to 28
`define SOC_REGION_DMEM 4'h0
`define SOC_REGION_GPIO 4'h2

// gpio register offsets inside its region
`define SOC_GPIO_OUT_OFS 8'h00
`define SOC_GPIO_OE_OFS  8'h04
`define SOC_GPIO_IN_OFS  8'h08

`endif
